//--- verilog/uart_bridge_pkg.sv
/*
 * Shared definitions for the UART register bridge
 *   Serial timing constants and bit counter type
 *   Transmit queue depth
 *   Byte and address types
 *   Opcode enum and the receive, transmit and parser state enums
 */

package uart_bridge_pkg;

    // ==================================================
    // Timing
    // ==================================================
    localparam int CLK_FREQ     = 27_000_000;            // System clock in Hz
    localparam int BAUD_RATE    = 115_200;
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;  // 234 clocks per bit
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t BIT_LAST = cnt_t'(CLKS_PER_BIT - 1);  // Count down to zero
    localparam cnt_t HALF_BIT = cnt_t'(CLKS_PER_BIT / 2);  // Start bit mid-point

    localparam int TXQ_DEPTH = 256;

    // ==================================================
    // Data types
    // ==================================================
    typedef logic [7:0] byte_t;
    typedef logic [7:0] addr_t;

    // ASCII command opcodes
    typedef enum logic [7:0] {
        CMD_WRITE       = 8'h57,  // 'W'
        CMD_WRITE_LC    = 8'h77,  // 'w'
        CMD_READ        = 8'h52,  // 'R'
        CMD_READ_LC     = 8'h72,  // 'r'
        CMD_BLOCK_WRITE = 8'h42,  // 'B'
        CMD_BLOCK_READ  = 8'h62   // 'b'
    } cmd_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    typedef enum logic [2:0] {
        P_IDLE, P_ADDR, P_LENGTH, P_WRITE_DATA,
        P_READ_ADDR, P_READ_EN, P_READ_CAPTURE, P_DRAIN
    } parse_state_t;

endpackage

//--- verilog/reg_bus_if.sv
/*
 * Register bank bus
 *   Address, write data, read data and the two enables
 *   Modport for the command parser and its mirror for the top level
 */

`timescale 1ns/10ps

interface reg_bus_if;

    uart_bridge_pkg::addr_t address;
    uart_bridge_pkg::byte_t wdata;
    uart_bridge_pkg::byte_t rdata;     // Valid one cycle after reg_en
    logic                   reg_en;
    logic                   write_en;  // Pulses together with reg_en

    modport cmd_parser (
        output address, wdata, reg_en, write_en,
        input  rdata
    );

    modport top (
        input  address, wdata, reg_en, write_en,
        output rdata
    );

endinterface

//--- verilog/uart_rx.sv
/*
 * UART receiver
 *   Two-flop synchronizer on the serial line
 *   Mid-bit sampling FSM, 8N1, LSB first
 *   One-cycle byte strobe at the stop bit
 */

`timescale 1ns/10ps

module uart_rx (
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   rx,
    output uart_bridge_pkg::byte_t rx_data,
    output logic                   rx_valid
);

    logic                         rx_meta;
    logic                         rx_sync;
    uart_bridge_pkg::rx_state_t   state;
    uart_bridge_pkg::cnt_t        cnt;
    logic [2:0]                   bit_idx;
    uart_bridge_pkg::byte_t       shift;

    // Line idles high
    always_ff @(posedge clk) begin
        if (!resetb) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ==================================================
    // Receive FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!resetb) begin
            state    <= uart_bridge_pkg::RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                uart_bridge_pkg::RX_IDLE: begin
                    if (!rx_sync) begin  // First low sample
                        state <= uart_bridge_pkg::RX_START;
                        cnt   <= uart_bridge_pkg::HALF_BIT;
                    end
                end
                uart_bridge_pkg::RX_START: begin
                    if (cnt == '0) begin
                        if (!rx_sync) begin
                            state   <= uart_bridge_pkg::RX_DATA;
                            cnt     <= uart_bridge_pkg::BIT_LAST;
                            bit_idx <= '0;
                        end else begin
                            state <= uart_bridge_pkg::RX_IDLE;  // Glitch, not a start bit
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                uart_bridge_pkg::RX_DATA: begin
                    if (cnt == '0) begin
                        shift   <= {rx_sync, shift[7:1]};
                        cnt     <= uart_bridge_pkg::BIT_LAST;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_bridge_pkg::RX_STOP;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                uart_bridge_pkg::RX_STOP: begin
                    // Stop bit level is not checked
                    if (cnt == '0) begin
                        rx_data  <= shift;
                        rx_valid <= 1'b1;
                        state    <= uart_bridge_pkg::RX_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= uart_bridge_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/uart_tx.sv
/*
 * UART transmitter
 *   Pops one byte from the reply queue when idle
 *   Sends start, 8 data bits LSB first and stop
 */

`timescale 1ns/10ps

module uart_tx (
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   empty,
    input  uart_bridge_pkg::byte_t pop_data,
    output logic                   pop,
    output logic                   tx
);

    uart_bridge_pkg::tx_state_t state;
    uart_bridge_pkg::cnt_t      cnt;
    logic [2:0]                 bit_idx;
    uart_bridge_pkg::byte_t     shift;

    // Leaves TX_IDLE on the same edge, so one cycle wide
    assign pop = (state == uart_bridge_pkg::TX_IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (!resetb) begin
            state   <= uart_bridge_pkg::TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            case (state)
                uart_bridge_pkg::TX_IDLE: begin
                    tx <= 1'b1;
                    if (!empty) begin
                        shift <= pop_data;
                        tx    <= 1'b0;  // Start bit
                        cnt   <= uart_bridge_pkg::BIT_LAST;
                        state <= uart_bridge_pkg::TX_START;
                    end
                end
                uart_bridge_pkg::TX_START: begin
                    if (cnt == '0) begin
                        tx      <= shift[0];
                        cnt     <= uart_bridge_pkg::BIT_LAST;
                        bit_idx <= '0;
                        state   <= uart_bridge_pkg::TX_DATA;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                uart_bridge_pkg::TX_DATA: begin
                    if (cnt == '0) begin
                        cnt     <= uart_bridge_pkg::BIT_LAST;
                        shift   <= {1'b0, shift[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;  // Stop bit
                            state <= uart_bridge_pkg::TX_STOP;
                        end else begin
                            tx <= shift[1];
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                uart_bridge_pkg::TX_STOP: begin
                    if (cnt == '0) begin
                        state <= uart_bridge_pkg::TX_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= uart_bridge_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/tx_queue.sv
/*
 * Reply byte queue
 *   256-entry circular memory
 *   Free-wrapping read and write pointers, empty on equality
 */

`timescale 1ns/10ps

module tx_queue (
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   push,
    input  uart_bridge_pkg::byte_t push_data,
    input  logic                   pop,
    output uart_bridge_pkg::byte_t pop_data,
    output logic                   empty
);

    localparam int PTR_W = $clog2(uart_bridge_pkg::TXQ_DEPTH);

    uart_bridge_pkg::byte_t mem [uart_bridge_pkg::TXQ_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at the queue depth without extra logic
    always_ff @(posedge clk) begin
        if (!resetb) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign empty    = (wr_ptr == rd_ptr);
    assign pop_data = mem[rd_ptr];  // Head of queue

endmodule

//--- verilog/cmd_parser.sv
/*
 * Command parser
 *   Decodes W/w, R/r, B and b commands from received bytes
 *   Drives the register bus for single and block accesses
 *   Pushes read data into the reply queue, then waits for it to drain
 */

`timescale 1ns/10ps

module cmd_parser (
    input  logic                   clk,
    input  logic                   resetb,
    input  uart_bridge_pkg::byte_t rx_data,
    input  logic                   rx_valid,
    input  logic                   queue_empty,
    output logic                   push,
    output uart_bridge_pkg::byte_t push_data,
    reg_bus_if.cmd_parser          bus
);

    uart_bridge_pkg::parse_state_t state;
    uart_bridge_pkg::cmd_t         cmd;
    uart_bridge_pkg::byte_t        length;
    uart_bridge_pkg::byte_t        count;   // Bytes done in this command
    logic                          last_byte;

    assign last_byte = ((count + 8'd1) == length);

    // rdata is valid in the second reg_en cycle
    assign push      = (state == uart_bridge_pkg::P_READ_CAPTURE);
    assign push_data = bus.rdata;

    always_ff @(posedge clk) begin
        if (!resetb) begin
            state        <= uart_bridge_pkg::P_IDLE;
            bus.reg_en   <= 1'b0;
            bus.write_en <= 1'b0;
        end else begin
            bus.reg_en   <= 1'b0;
            bus.write_en <= 1'b0;

            // Step to the next address once a write pulse is done
            if (bus.write_en) begin
                bus.address <= bus.address + 8'd1;
            end

            case (state)
                // ==================================================
                // Command, address and length bytes
                // ==================================================
                uart_bridge_pkg::P_IDLE: begin
                    if (rx_valid && queue_empty) begin
                        case (rx_data)
                            uart_bridge_pkg::CMD_WRITE,
                            uart_bridge_pkg::CMD_WRITE_LC,
                            uart_bridge_pkg::CMD_READ,
                            uart_bridge_pkg::CMD_READ_LC,
                            uart_bridge_pkg::CMD_BLOCK_WRITE,
                            uart_bridge_pkg::CMD_BLOCK_READ: begin
                                cmd   <= uart_bridge_pkg::cmd_t'(rx_data);
                                state <= uart_bridge_pkg::P_ADDR;
                            end
                            default: ;  // Unknown byte is ignored
                        endcase
                    end
                end
                uart_bridge_pkg::P_ADDR: begin
                    if (rx_valid) begin
                        bus.address <= rx_data;
                        count       <= '0;
                        length      <= 8'd1;  // Single access is a block of one
                        case (cmd)
                            uart_bridge_pkg::CMD_WRITE,
                            uart_bridge_pkg::CMD_WRITE_LC: state <= uart_bridge_pkg::P_WRITE_DATA;
                            uart_bridge_pkg::CMD_READ,
                            uart_bridge_pkg::CMD_READ_LC:  state <= uart_bridge_pkg::P_READ_ADDR;
                            default:                       state <= uart_bridge_pkg::P_LENGTH;
                        endcase
                    end
                end
                uart_bridge_pkg::P_LENGTH: begin
                    if (rx_valid) begin
                        length <= rx_data;
                        if (rx_data == 8'd0) begin
                            state <= uart_bridge_pkg::P_IDLE;  // Empty block
                        end else if (cmd == uart_bridge_pkg::CMD_BLOCK_WRITE) begin
                            state <= uart_bridge_pkg::P_WRITE_DATA;
                        end else begin
                            state <= uart_bridge_pkg::P_READ_ADDR;
                        end
                    end
                end

                // ==================================================
                // Write and read sequencing
                // ==================================================
                uart_bridge_pkg::P_WRITE_DATA: begin
                    if (rx_valid) begin
                        bus.wdata    <= rx_data;
                        bus.reg_en   <= 1'b1;
                        bus.write_en <= 1'b1;
                        count        <= count + 8'd1;
                        if (last_byte) begin
                            state <= uart_bridge_pkg::P_IDLE;
                        end
                    end
                end
                uart_bridge_pkg::P_READ_ADDR: begin
                    bus.reg_en <= 1'b1;  // Address already stable
                    state      <= uart_bridge_pkg::P_READ_EN;
                end
                uart_bridge_pkg::P_READ_EN: begin
                    bus.reg_en <= 1'b1;
                    state      <= uart_bridge_pkg::P_READ_CAPTURE;
                end
                uart_bridge_pkg::P_READ_CAPTURE: begin
                    count       <= count + 8'd1;
                    bus.address <= bus.address + 8'd1;  // Wraps at 255
                    state       <= last_byte ? uart_bridge_pkg::P_DRAIN
                                             : uart_bridge_pkg::P_READ_ADDR;
                end
                uart_bridge_pkg::P_DRAIN: begin
                    // Bytes received here are dropped
                    if (queue_empty) begin
                        state <= uart_bridge_pkg::P_IDLE;
                    end
                end
                default: state <= uart_bridge_pkg::P_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/uart_reg_bridge.sv
/*
 * UART to register bank bridge, top level
 *   Receiver, command parser, reply queue and transmitter
 *   Register bus mapped to plain ports
 */

`timescale 1ns/10ps

module uart_reg_bridge (
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   uart_rx,
    output logic                   uart_tx,
    output uart_bridge_pkg::addr_t address,
    output uart_bridge_pkg::byte_t data_write_to_reg,
    input  uart_bridge_pkg::byte_t data_read_from_reg,
    output logic                   reg_en,
    output logic                   write_en
);

    uart_bridge_pkg::byte_t rx_data;
    logic                   rx_valid;
    logic                   push;
    uart_bridge_pkg::byte_t push_data;
    logic                   pop;
    uart_bridge_pkg::byte_t pop_data;
    logic                   queue_empty;

    reg_bus_if bus ();

    // Bus to pins
    assign address           = bus.address;
    assign data_write_to_reg = bus.wdata;
    assign reg_en            = bus.reg_en;
    assign write_en          = bus.write_en;
    assign bus.rdata         = data_read_from_reg;

    uart_rx uart_rx_inst (
        .clk      (clk),
        .resetb   (resetb),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    cmd_parser cmd_parser_inst (
        .clk         (clk),
        .resetb      (resetb),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .queue_empty (queue_empty),
        .push        (push),
        .push_data   (push_data),
        .bus         (bus.cmd_parser)
    );

    tx_queue tx_queue_inst (
        .clk       (clk),
        .resetb    (resetb),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (queue_empty)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .resetb   (resetb),
        .empty    (queue_empty),
        .pop_data (pop_data),
        .pop      (pop),
        .tx       (uart_tx)
    );

endmodule

//--- verif/uart_bfm.svh
/*
 * Serial helpers for the UART bridge testbench
 *   Byte sender on the DUT receive line
 *   Frame receiver that samples the tx line at mid-bit
 *   Typed compare tasks for bytes, write pulses and counts
 */

// Start bit, 8 data bits LSB first, stop bit
task automatic send_byte(input uart_bridge_pkg::byte_t value);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, value, 1'b0};
    for (i = 0; i < 10; i++) begin
        @(posedge clk);
        rx_line <= frame[i];
        repeat (uart_bridge_pkg::CLKS_PER_BIT - 1) @(posedge clk);
    end
endtask

// Called on the first low sample of a start bit
task automatic receive_frame();
    uart_bridge_pkg::byte_t value;
    int                     i;
    repeat (uart_bridge_pkg::CLKS_PER_BIT / 2) @(posedge clk);  // Middle of start bit
    for (i = 0; i < 8; i++) begin
        repeat (uart_bridge_pkg::CLKS_PER_BIT) @(posedge clk);
        value[i] = tx_line;
    end
    repeat (uart_bridge_pkg::CLKS_PER_BIT) @(posedge clk);      // Middle of stop bit
    reply_q.push_back(value);
endtask

// ==================================================
// Compare tasks
// ==================================================
task automatic check_byte(input string name, input uart_bridge_pkg::byte_t expected,
                          input uart_bridge_pkg::byte_t actual);
    if (actual !== expected) begin
        $display("MISMATCH %s: expected %02h, actual %02h", name, expected, actual);
        test_errors++;
    end
endtask

task automatic check_write(input string name,
                           input uart_bridge_pkg::addr_t exp_addr,
                           input uart_bridge_pkg::byte_t exp_data,
                           input uart_bridge_pkg::addr_t act_addr,
                           input uart_bridge_pkg::byte_t act_data);
    if (act_addr !== exp_addr || act_data !== exp_data) begin
        $display("MISMATCH %s: expected write %02h <= %02h, actual write %02h <= %02h",
                 name, exp_addr, exp_data, act_addr, act_data);
        test_errors++;
    end
endtask

task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
        $display("MISMATCH %s: expected count %0d, actual count %0d", name, expected, actual);
        test_errors++;
    end
endtask

//--- verif/tb_uart_reg_bridge.sv
/*
 * Testbench for the UART register bridge
 *   Clock, reset and DUT instance
 *   Register bank model and reply monitor on the tx line
 *   Random single, block, zero-length and junk-byte tests
 *   One result line per test and a closing summary
 */

`timescale 1ns/10ps

module tb_uart_reg_bridge;

    logic                   clk     = 1'b0;
    logic                   resetb  = 1'b0;
    logic                   rx_line = 1'b1;   // Serial line idles high
    logic                   tx_line;
    uart_bridge_pkg::addr_t address;
    uart_bridge_pkg::byte_t wdata;
    uart_bridge_pkg::byte_t rdata   = '0;
    logic                   reg_en;
    logic                   write_en;

    uart_bridge_pkg::byte_t bank [256];           // Bank seen by the DUT
    uart_bridge_pkg::byte_t expected_bank [256];
    uart_bridge_pkg::byte_t reply_q [$];
    uart_bridge_pkg::addr_t wr_addr_q [$];        // One entry per write pulse
    uart_bridge_pkg::byte_t wr_data_q [$];
    int                     reg_en_cycles = 0;
    int                     test_errors   = 0;
    int                     pass_count    = 0;
    int                     fail_count    = 0;
    bit                     timed_out     = 1'b0;

    `include "uart_bfm.svh"

    uart_reg_bridge uart_reg_bridge_inst (
        .clk                (clk),
        .resetb             (resetb),
        .uart_rx            (rx_line),
        .uart_tx            (tx_line),
        .address            (address),
        .data_write_to_reg  (wdata),
        .data_read_from_reg (rdata),
        .reg_en             (reg_en),
        .write_en           (write_en)
    );

    always #5 clk = ~clk;

    function automatic uart_bridge_pkg::byte_t fill_value(input int a);
        return uart_bridge_pkg::byte_t'(a * 37 + 11);  // Odd multiplier gives one value per address
    endfunction

    function automatic bit is_command(input uart_bridge_pkg::byte_t b);
        return b inside {uart_bridge_pkg::CMD_WRITE, uart_bridge_pkg::CMD_WRITE_LC,
                         uart_bridge_pkg::CMD_READ, uart_bridge_pkg::CMD_READ_LC,
                         uart_bridge_pkg::CMD_BLOCK_WRITE, uart_bridge_pkg::CMD_BLOCK_READ};
    endfunction

    // ==================================================
    // Register bank model and reply monitor
    // ==================================================
    always @(posedge clk) begin
        if (!resetb) begin
            foreach (bank[i]) begin
                bank[i] <= fill_value(i);
            end
        end else if (reg_en) begin
            reg_en_cycles <= reg_en_cycles + 1;
            rdata         <= bank[address];  // Valid one cycle after reg_en
            if (write_en) begin
                bank[address] <= wdata;
                wr_addr_q.push_back(address);
                wr_data_q.push_back(wdata);
            end
        end
    end

    always @(posedge clk) begin
        if (resetb && tx_line === 1'b0) begin
            receive_frame();
        end
    end

    // Waits for reply bytes or write pulses with a limit in bit times
    task automatic wait_for(input bit writes, input int target, input int bits,
                            input string what);
        int cycles;
        cycles = 0;
        while ((writes ? wr_addr_q.size() : reply_q.size()) < target &&
               cycles < bits * uart_bridge_pkg::CLKS_PER_BIT) begin
            @(posedge clk);
            cycles++;
        end
        if ((writes ? wr_addr_q.size() : reply_q.size()) < target) begin
            $display("Timeout: the %s never arrived", what);
            timed_out = 1'b1;
            test_errors++;
        end
    endtask

    task automatic settle(input int bits);
        repeat (bits * uart_bridge_pkg::CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: PASS", name);
        end else begin
            fail_count++;
            $display("test %s: FAIL with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic test_reset_idle();
        int bad;
        bad = 0;
        repeat (100) begin
            @(posedge clk);
            if (tx_line !== 1'b1 || reg_en !== 1'b0 || write_en !== 1'b0) begin
                bad++;
            end
        end
        check_count("reset_idle", 0, bad);
        finish_test("reset_idle");
    endtask

    task automatic test_single_writes();
        uart_bridge_pkg::addr_t a;
        uart_bridge_pkg::byte_t d;
        int                     base;
        int                     n;
        for (n = 0; n < 8; n++) begin
            a    = uart_bridge_pkg::addr_t'($urandom);
            d    = uart_bridge_pkg::byte_t'($urandom);
            base = wr_addr_q.size();
            send_byte(n[0] ? uart_bridge_pkg::CMD_WRITE_LC : uart_bridge_pkg::CMD_WRITE);
            send_byte(a);
            send_byte(d);
            expected_bank[a] = d;
            wait_for(1'b1, base + 1, 2, "single write pulse");
            settle(2);
            check_count("single_write", 1, wr_addr_q.size() - base);
            if (wr_addr_q.size() > base) begin
                check_write("single_write", a, d, wr_addr_q[base], wr_data_q[base]);
            end
            check_byte("single_write", expected_bank[a], bank[a]);
        end
        finish_test("single_write");
    endtask

    task automatic read_one(input string name, input uart_bridge_pkg::byte_t cmd);
        uart_bridge_pkg::addr_t a;
        int                     base;
        a    = uart_bridge_pkg::addr_t'($urandom);
        base = reply_q.size();
        send_byte(cmd);
        send_byte(a);
        wait_for(1'b0, base + 1, 15, "single read reply");
        settle(12);  // Room for an extra frame to show up
        check_count(name, 1, reply_q.size() - base);
        if (reply_q.size() > base) begin
            check_byte(name, expected_bank[a], reply_q[base]);
        end
    endtask

    task automatic test_single_reads();
        int n;
        for (n = 0; n < 6; n++) begin
            read_one("single_read", n[0] ? uart_bridge_pkg::CMD_READ_LC
                                         : uart_bridge_pkg::CMD_READ);
        end
        finish_test("single_read");
    endtask

    task automatic test_block();
        uart_bridge_pkg::addr_t start;
        uart_bridge_pkg::addr_t a;
        uart_bridge_pkg::byte_t d;
        int                     len;
        int                     base;
        int                     k;
        start = uart_bridge_pkg::addr_t'(245 + $urandom_range(10));  // Wraps past 255
        len   = $urandom_range(20, 1);
        base  = wr_addr_q.size();
        send_byte(uart_bridge_pkg::CMD_BLOCK_WRITE);
        send_byte(start);
        send_byte(uart_bridge_pkg::byte_t'(len));
        for (k = 0; k < len; k++) begin
            d = uart_bridge_pkg::byte_t'($urandom);
            expected_bank[uart_bridge_pkg::addr_t'(start + k)] = d;
            send_byte(d);
        end
        wait_for(1'b1, base + len, 2, "block write pulses");
        check_count("block_write", len, wr_addr_q.size() - base);
        for (k = 0; k < len && base + k < wr_addr_q.size(); k++) begin
            a = uart_bridge_pkg::addr_t'(start + k);
            check_write("block_write", a, expected_bank[a], wr_addr_q[base + k],
                        wr_data_q[base + k]);
        end
        finish_test("block_write");

        base = reply_q.size();
        send_byte(uart_bridge_pkg::CMD_BLOCK_READ);
        send_byte(start);
        send_byte(uart_bridge_pkg::byte_t'(len));
        wait_for(1'b0, base + len, len * 10 + 15, "block read reply");
        settle(12);
        check_count("block_read", len, reply_q.size() - base);
        for (k = 0; k < len && base + k < reply_q.size(); k++) begin
            check_byte("block_read", expected_bank[uart_bridge_pkg::addr_t'(start + k)],
                       reply_q[base + k]);
        end
        finish_test("block_read");
    endtask

    task automatic test_zero_length();
        int en_base;
        int reply_base;
        en_base    = reg_en_cycles;
        reply_base = reply_q.size();
        send_byte(uart_bridge_pkg::CMD_BLOCK_WRITE);
        send_byte(uart_bridge_pkg::addr_t'($urandom));
        send_byte(8'd0);
        send_byte(uart_bridge_pkg::CMD_BLOCK_READ);
        send_byte(uart_bridge_pkg::addr_t'($urandom));
        send_byte(8'd0);
        settle(15);
        check_count("zero_length", 0, reg_en_cycles - en_base);
        check_count("zero_length", 0, reply_q.size() - reply_base);
        finish_test("zero_length");
    endtask

    task automatic test_junk_then_read();
        uart_bridge_pkg::byte_t junk;
        int                     n;
        int                     count;
        count = $urandom_range(4, 1);
        for (n = 0; n < count; n++) begin
            junk = uart_bridge_pkg::byte_t'($urandom);
            while (is_command(junk)) begin
                junk = uart_bridge_pkg::byte_t'($urandom);
            end
            send_byte(junk);
        end
        read_one("junk_then_read", uart_bridge_pkg::CMD_READ_LC);
        finish_test("junk_then_read");
    endtask

    initial begin
        void'($urandom(84));
        foreach (expected_bank[i]) begin
            expected_bank[i] = fill_value(i);
        end
        repeat (2) @(posedge clk);
        resetb <= 1'b1;
        test_reset_idle();
        test_single_writes();
        test_single_reads();
        test_block();
        test_zero_length();
        test_junk_then_read();
        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+verif
verilog/uart_bridge_pkg.sv
verilog/reg_bus_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/tx_queue.sv
verilog/cmd_parser.sv
verilog/uart_reg_bridge.sv
verif/tb_uart_reg_bridge.sv

//--- run.sh
#!/bin/sh
# Build the UART register bridge testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/10ps \
    --top-module tb_uart_reg_bridge \
    -f all.f \
    -o tb_uart_reg_bridge

./obj_dir/tb_uart_reg_bridge | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
